//--- files.f
src/axis_cfg_pkg.sv
src/pkt_fmt_pkg.sv
src/axis_skid_reg.sv
src/pkt_transform.sv
src/pkt_length_check.sv
src/stream_pipe_top.sv
tb/stream_pipe_chk.sv
tb/stream_pipe_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the stream pipeline testbench, pass only if the log holds the pass line
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert -f files.f --top-module stream_pipe_tb &&
./obj_dir/Vstream_pipe_tb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^ALL CHECKS PASSED$" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

//--- src/axis_cfg_pkg.sv
// stream geometry and slice codes; pkt_fmt_pkg assumes DATA_WIDTH stays at 32
package axis_cfg_pkg;

    // width of one stream beat
    // every beat is a full word, so no byte enables travel with it
    localparam int DATA_WIDTH = 32;

    // user sideband width
    // bit 0 flags a length error on the pipeline output
    localparam int USER_WIDTH = 1;

    // register slice build options
    // bypass: plain wires, no latency and no timing break
    localparam logic [1:0] REG_BYPASS = 2'd0;

    // simple: one register, inserts a bubble after every beat
    localparam logic [1:0] REG_SIMPLE = 2'd1;

    // skid: output plus temp register, full throughput with registered ready
    localparam logic [1:0] REG_SKID = 2'd2;

endpackage

//--- src/axis_skid_reg.sv
// valid/ready slice; type code 3 is undefined and builds as the skid variant
`timescale 1ns/1ns

module axis_skid_reg #(
    parameter logic [1:0] REG_TYPE = axis_cfg_pkg::REG_SKID
) (
    input  logic                              clk,
    input  logic                              rst,

    input  logic [axis_cfg_pkg::DATA_WIDTH-1:0] s_tdata,
    input  logic                              s_tlast,
    input  logic [axis_cfg_pkg::USER_WIDTH-1:0] s_tuser,
    input  logic                              s_tvalid,
    output logic                              s_tready,

    output logic [axis_cfg_pkg::DATA_WIDTH-1:0] m_tdata,
    output logic                              m_tlast,
    output logic [axis_cfg_pkg::USER_WIDTH-1:0] m_tuser,
    output logic                              m_tvalid,
    input  logic                              m_tready
);

    if (REG_TYPE == axis_cfg_pkg::REG_BYPASS) begin : g_bypass
        // pure wires, ready passes straight back
        assign m_tdata  = s_tdata;
        assign m_tlast  = s_tlast;
        assign m_tuser  = s_tuser;
        assign m_tvalid = s_tvalid;
        assign s_tready = m_tready;

    end else if (REG_TYPE == axis_cfg_pkg::REG_SIMPLE) begin : g_simple
        logic ready_q;
        logic valid_q;
        logic valid_d;

        assign s_tready = ready_q;
        assign m_tvalid = valid_q;

        // ready only while the register is empty, so every beat is followed by a bubble
        always_comb begin
            valid_d = valid_q;
            if (ready_q) begin
                valid_d = s_tvalid;
            end else if (m_tready) begin
                valid_d = 1'b0;
            end
        end

        always_ff @(posedge clk) begin
            if (rst) begin
                ready_q <= 1'b0;
                valid_q <= 1'b0;
            end else begin
                ready_q <= !valid_d;
                valid_q <= valid_d;
            end
        end

        always_ff @(posedge clk) begin
            if (ready_q) begin
                m_tdata <= s_tdata;
                m_tlast <= s_tlast;
                m_tuser <= s_tuser;
            end
        end

    end else begin : g_skid
        logic                              ready_q;
        logic                              valid_q;
        logic                              valid_d;
        logic                              tmp_valid_q;
        logic                              tmp_valid_d;
        logic [axis_cfg_pkg::DATA_WIDTH-1:0] tmp_data_q;
        logic                              tmp_last_q;
        logic [axis_cfg_pkg::USER_WIDTH-1:0] tmp_user_q;
        logic                              in_to_out;
        logic                              in_to_tmp;
        logic                              tmp_to_out;
        logic                              ready_d;

        assign s_tready = ready_q;
        assign m_tvalid = valid_q;

        // keep ready up next cycle unless the temp register could fill
        assign ready_d = m_tready || (!tmp_valid_q && (!valid_q || !s_tvalid));

        always_comb begin
            valid_d     = valid_q;
            tmp_valid_d = tmp_valid_q;
            in_to_out   = 1'b0;
            in_to_tmp   = 1'b0;
            tmp_to_out  = 1'b0;
            if (ready_q) begin
                if (m_tready || !valid_q) begin
                    // output free, load it directly
                    valid_d   = s_tvalid;
                    in_to_out = 1'b1;
                end else begin
                    // output stalled, park the beat in temp
                    tmp_valid_d = s_tvalid;
                    in_to_tmp   = 1'b1;
                end
            end else if (m_tready) begin
                // drain temp into the output register
                valid_d     = tmp_valid_q;
                tmp_valid_d = 1'b0;
                tmp_to_out  = 1'b1;
            end
        end

        always_ff @(posedge clk) begin
            if (rst) begin
                ready_q     <= 1'b0;
                valid_q     <= 1'b0;
                tmp_valid_q <= 1'b0;
            end else begin
                ready_q     <= ready_d;
                valid_q     <= valid_d;
                tmp_valid_q <= tmp_valid_d;
            end
        end

        always_ff @(posedge clk) begin
            if (in_to_out) begin
                m_tdata <= s_tdata;
                m_tlast <= s_tlast;
                m_tuser <= s_tuser;
            end else if (tmp_to_out) begin
                m_tdata <= tmp_data_q;
                m_tlast <= tmp_last_q;
                m_tuser <= tmp_user_q;
            end
            if (in_to_tmp) begin
                tmp_data_q <= s_tdata;
                tmp_last_q <= s_tlast;
                tmp_user_q <= s_tuser;
            end
        end
    end

endmodule

//--- src/pkt_fmt_pkg.sv
// packet word layout; the header is exactly 32 bits and must match the stream width
package pkt_fmt_pkg;

    // operation applied to every payload word of a packet
    typedef enum logic [1:0] {
        // payload unchanged
        OP_PASS = 2'd0,
        // xor with the key repeated across the word
        OP_XOR  = 2'd1,
        // add zero-extended key, wraps modulo 2^32
        OP_ADD  = 2'd2,
        // byte order reversed
        OP_SWAP = 2'd3
    } opcode_e;

    // first beat of each packet, msb first
    typedef struct packed {
        opcode_e     opcode;
        // destination tag, carried but not acted on in this pipeline
        logic [5:0]  dest;
        // expected number of payload words after the header
        logic [7:0]  length;
        logic [15:0] key;
    } pkt_header_t;

    // one stream beat, read as a header on the first beat of a packet
    // and as plain data on every payload beat
    typedef union packed {
        pkt_header_t                    hdr;
        logic [$bits(pkt_header_t)-1:0] data;
    } stream_word_u;

endpackage

//--- src/pkt_length_check.sv
// error is reported on the tlast beat only; counts above 255 always flag a mismatch
`timescale 1ns/1ns

module pkt_length_check (
    input  logic                              clk,
    input  logic                              rst,

    input  logic [axis_cfg_pkg::DATA_WIDTH-1:0] s_tdata,
    input  logic                              s_tlast,
    input  logic                              s_tvalid,
    output logic                              s_tready,

    output logic [axis_cfg_pkg::DATA_WIDTH-1:0] m_tdata,
    output logic                              m_tlast,
    output logic [axis_cfg_pkg::USER_WIDTH-1:0] m_tuser,
    output logic                              m_tvalid,
    input  logic                              m_tready
);

    pkt_fmt_pkg::stream_word_u in_word;
    logic                      sop_q;
    logic [7:0]                len_q;
    // saturates, so a long packet never wraps back to a match
    logic [8:0]                cnt_q;
    logic                      len_err;
    logic                      take;
    logic [axis_cfg_pkg::USER_WIDTH-1:0] user_d;

    assign in_word  = s_tdata;
    assign s_tready = !m_tvalid || m_tready;
    assign take     = s_tvalid && s_tready;

    // header-only packet is fine only when it announces zero payload
    always_comb begin
        if (sop_q) begin
            len_err = (in_word.hdr.length != 8'd0);
        end else begin
            len_err = (({1'b0, cnt_q} + 10'd1) != {2'b00, len_q});
        end
        user_d    = '0;
        user_d[0] = s_tlast && len_err;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            m_tvalid <= 1'b0;
            sop_q    <= 1'b1;
        end else if (take) begin
            m_tvalid <= 1'b1;
            sop_q    <= s_tlast;
        end else if (m_tready) begin
            m_tvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            m_tdata <= s_tdata;
            m_tlast <= s_tlast;
            m_tuser <= user_d;
            if (sop_q) begin
                len_q <= in_word.hdr.length;
                cnt_q <= 9'd0;
            end else if (cnt_q != 9'h1ff) begin
                cnt_q <= cnt_q + 9'd1;
            end
        end
    end

endmodule

//--- src/pkt_transform.sv
// first beat after reset or after tlast is taken as a header; no framing recovery
`timescale 1ns/1ns

module pkt_transform (
    input  logic                              clk,
    input  logic                              rst,

    input  logic [axis_cfg_pkg::DATA_WIDTH-1:0] s_tdata,
    input  logic                              s_tlast,
    input  logic                              s_tvalid,
    output logic                              s_tready,

    output logic [axis_cfg_pkg::DATA_WIDTH-1:0] m_tdata,
    output logic                              m_tlast,
    output logic                              m_tvalid,
    input  logic                              m_tready
);

    pkt_fmt_pkg::stream_word_u in_word;
    pkt_fmt_pkg::opcode_e      op_q;
    logic [15:0]               key_q;
    logic                      sop_q;
    logic                      take;
    logic [axis_cfg_pkg::DATA_WIDTH-1:0] payload;

    assign in_word = s_tdata;

    // single entry, refills in the same cycle it drains
    assign s_tready = !m_tvalid || m_tready;
    assign take     = s_tvalid && s_tready;

    // operation from the latched header, applied to the incoming word
    always_comb begin
        case (op_q)
            pkt_fmt_pkg::OP_XOR: begin
                payload = in_word.data ^ {2{key_q}};
            end
            pkt_fmt_pkg::OP_ADD: begin
                payload = in_word.data + {16'h0000, key_q};
            end
            pkt_fmt_pkg::OP_SWAP: begin
                payload = {in_word.data[7:0], in_word.data[15:8],
                           in_word.data[23:16], in_word.data[31:24]};
            end
            default: begin
                payload = in_word.data;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            m_tvalid <= 1'b0;
            sop_q    <= 1'b1;
        end else if (take) begin
            m_tvalid <= 1'b1;
            // next beat opens a packet once this one closes it
            sop_q    <= s_tlast;
        end else if (m_tready) begin
            m_tvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            m_tlast <= s_tlast;
            if (sop_q) begin
                // header leaves untouched
                m_tdata <= in_word.data;
                op_q    <= in_word.hdr.opcode;
                key_q   <= in_word.hdr.key;
            end else begin
                m_tdata <= payload;
            end
        end
    end

endmodule

//--- src/stream_pipe_top.sv
// four cycle latency with skid slices; incoming user sideband is ignored
`timescale 1ns/1ns

module stream_pipe_top #(
    parameter logic [1:0] IN_REG_TYPE  = axis_cfg_pkg::REG_SKID,
    parameter logic [1:0] OUT_REG_TYPE = axis_cfg_pkg::REG_SKID
) (
    input  logic                              clk,
    input  logic                              rst,

    input  logic [axis_cfg_pkg::DATA_WIDTH-1:0] s_tdata,
    input  logic                              s_tlast,
    input  logic                              s_tvalid,
    output logic                              s_tready,

    output logic [axis_cfg_pkg::DATA_WIDTH-1:0] m_tdata,
    output logic                              m_tlast,
    output logic [axis_cfg_pkg::USER_WIDTH-1:0] m_tuser,
    output logic                              m_tvalid,
    input  logic                              m_tready
);

    // input slice to transform
    logic [axis_cfg_pkg::DATA_WIDTH-1:0] in_tdata;
    logic                              in_tlast;
    logic                              in_tvalid;
    logic                              in_tready;

    // transform to length check
    logic [axis_cfg_pkg::DATA_WIDTH-1:0] xf_tdata;
    logic                              xf_tlast;
    logic                              xf_tvalid;
    logic                              xf_tready;

    // length check to output slice
    logic [axis_cfg_pkg::DATA_WIDTH-1:0] lc_tdata;
    logic                              lc_tlast;
    logic [axis_cfg_pkg::USER_WIDTH-1:0] lc_tuser;
    logic                              lc_tvalid;
    logic                              lc_tready;

    // user bit is rewritten by the length check, nothing to carry in
    axis_skid_reg #(.REG_TYPE(IN_REG_TYPE)) in_reg_i (
        .clk(clk), .rst(rst),
        .s_tdata(s_tdata), .s_tlast(s_tlast), .s_tuser('0),
        .s_tvalid(s_tvalid), .s_tready(s_tready),
        .m_tdata(in_tdata), .m_tlast(in_tlast), .m_tuser(),
        .m_tvalid(in_tvalid), .m_tready(in_tready)
    );

    pkt_transform xform_i (
        .clk(clk), .rst(rst),
        .s_tdata(in_tdata), .s_tlast(in_tlast),
        .s_tvalid(in_tvalid), .s_tready(in_tready),
        .m_tdata(xf_tdata), .m_tlast(xf_tlast),
        .m_tvalid(xf_tvalid), .m_tready(xf_tready)
    );

    pkt_length_check len_chk_i (
        .clk(clk), .rst(rst),
        .s_tdata(xf_tdata), .s_tlast(xf_tlast),
        .s_tvalid(xf_tvalid), .s_tready(xf_tready),
        .m_tdata(lc_tdata), .m_tlast(lc_tlast), .m_tuser(lc_tuser),
        .m_tvalid(lc_tvalid), .m_tready(lc_tready)
    );

    axis_skid_reg #(.REG_TYPE(OUT_REG_TYPE)) out_reg_i (
        .clk(clk), .rst(rst),
        .s_tdata(lc_tdata), .s_tlast(lc_tlast), .s_tuser(lc_tuser),
        .s_tvalid(lc_tvalid), .s_tready(lc_tready),
        .m_tdata(m_tdata), .m_tlast(m_tlast), .m_tuser(m_tuser),
        .m_tvalid(m_tvalid), .m_tready(m_tready)
    );

endmodule

//--- tb/stream_pipe_chk.sv
// handshake properties on the pipeline output, sampled on clk; needs rst held at least two cycles
`timescale 1ns/1ns

module stream_pipe_chk (
    input logic                              clk,
    input logic                              rst,
    input logic                              s_tready,
    input logic [axis_cfg_pkg::DATA_WIDTH-1:0] m_tdata,
    input logic                              m_tlast,
    input logic [axis_cfg_pkg::USER_WIDTH-1:0] m_tuser,
    input logic                              m_tvalid,
    input logic                              m_tready
);

    // no output beat while the pipeline sits in reset
    assert property (@(posedge clk) $past(rst) |-> !m_tvalid)
        else $error("m_tvalid high during reset");

    // a stalled beat must not change until it is taken
    assert property (@(posedge clk) disable iff (rst)
        (m_tvalid && !m_tready) |=> (m_tvalid && $stable(m_tdata) && $stable(m_tlast)
                                     && $stable(m_tuser)))
        else $error("output beat changed while stalled");

    // input slice needs one cycle before it takes data
    assert property (@(posedge clk) $fell(rst) |-> !s_tready)
        else $error("s_tready high in the first cycle after reset");

endmodule

bind stream_pipe_top stream_pipe_chk chk_i (
    .clk(clk), .rst(rst), .s_tready(s_tready),
    .m_tdata(m_tdata), .m_tlast(m_tlast), .m_tuser(m_tuser),
    .m_tvalid(m_tvalid), .m_tready(m_tready)
);

//--- tb/stream_pipe_tb.sv
// random packet test with skid slices on both ends; random payload counts stay below 8 words
`timescale 1ns/1ns

module stream_pipe_tb;

    localparam int unsigned TIMEOUT_CYCLES = 1000;

    logic                              clk = 1'b0;
    logic                              rst;
    logic [axis_cfg_pkg::DATA_WIDTH-1:0] s_tdata;
    logic                              s_tlast;
    logic                              s_tvalid;
    logic                              s_tready;
    logic [axis_cfg_pkg::DATA_WIDTH-1:0] m_tdata;
    logic                              m_tlast;
    logic [axis_cfg_pkg::USER_WIDTH-1:0] m_tuser;
    logic                              m_tvalid;
    logic                              m_tready = 1'b0;

    integer      seed = 53232;
    logic [33:0] exp_q[$];
    int          err_count = 0;
    int          timeout_count = 0;
    bit          timed_out = 1'b0;
    bit          random_ready = 1'b1;
    bit          gapless = 1'b0;
    int          cycle = 0;
    int          prev_cycle = 0;
    int          burst_outs = 0;

    stream_pipe_top #(
        .IN_REG_TYPE(axis_cfg_pkg::REG_SKID),
        .OUT_REG_TYPE(axis_cfg_pkg::REG_SKID)
    ) stream_pipe_top_i (
        .clk(clk), .rst(rst),
        .s_tdata(s_tdata), .s_tlast(s_tlast), .s_tvalid(s_tvalid), .s_tready(s_tready),
        .m_tdata(m_tdata), .m_tlast(m_tlast), .m_tuser(m_tuser),
        .m_tvalid(m_tvalid), .m_tready(m_tready)
    );

    always #5 clk = ~clk;

    function automatic int unsigned rand_below(int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    // expected payload word for a header operation
    function automatic logic [31:0] ref_transform(logic [1:0] op, logic [15:0] key,
                                                  logic [31:0] w);
        logic [31:0] r;
        r = w;
        if (op == pkt_fmt_pkg::OP_XOR) begin
            r = w ^ {key, key};
        end else if (op == pkt_fmt_pkg::OP_ADD) begin
            // wide sum, upper bits dropped for modulo 2^32
            r = 32'(64'(w) + 64'(key));
        end else if (op == pkt_fmt_pkg::OP_SWAP) begin
            for (int b = 0; b < 4; b++) begin
                r[8*b +: 8] = w[8*(3-b) +: 8];
            end
        end
        return r;
    endfunction

    task automatic check_value(string what, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
            err_count++;
        end
    endtask

    task automatic send_beat(logic [31:0] data, logic last, bit gaps);
        int unsigned n;
        logic        accepted;
        if (timed_out) return;
        if (gaps) begin
            s_tvalid <= 1'b0;
            repeat (rand_below(3)) @(posedge clk);
        end
        s_tdata  <= data;
        s_tlast  <= last;
        s_tvalid <= 1'b1;
        n        = 0;
        accepted = 1'b0;
        while (!accepted && n < TIMEOUT_CYCLES) begin
            @(posedge clk);
            accepted = s_tready;
            n++;
        end
        if (!accepted) begin
            $display("timeout: s_tready stayed low for %0d cycles", TIMEOUT_CYCLES);
            timeout_count++;
            timed_out = 1'b1;
        end
    endtask

    task automatic send_packet(logic [1:0] op, logic bad_len, int unsigned count, bit gaps);
        pkt_fmt_pkg::stream_word_u hdr_w;
        logic [7:0]                length;
        logic [31:0]               word;
        logic                      last;
        logic                      user;
        length = 8'(count);
        if (bad_len) begin
            if (count > 0 && rand_below(2) == 0) length = 8'(count - 1);
            else length = 8'(count + 1 + rand_below(3));
        end
        hdr_w.hdr.opcode = pkt_fmt_pkg::opcode_e'(op);
        hdr_w.hdr.dest   = 6'(rand_below(64));
        hdr_w.hdr.length = length;
        hdr_w.hdr.key    = 16'($random(seed));
        // header goes out as is, flagged only when it is the whole packet
        last = (count == 0);
        user = last && (length != 8'd0);
        exp_q.push_back({user, last, hdr_w.data});
        send_beat(hdr_w.data, last, gaps);
        for (int unsigned i = 0; i < count; i++) begin
            word = $random(seed);
            last = (i == count - 1);
            user = last && (length != 8'(count));
            exp_q.push_back({user, last, ref_transform(op, hdr_w.hdr.key, word)});
            send_beat(word, last, gaps);
        end
    endtask

    task automatic wait_drained();
        int unsigned n;
        if (timed_out) return;
        n = 0;
        while (exp_q.size() != 0 && n < TIMEOUT_CYCLES) begin
            @(posedge clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout: %0d expected beats never left the pipeline", exp_q.size());
            timeout_count++;
            timed_out = 1'b1;
        end
    endtask

    // random back-pressure, or always ready for the streaming test
    always @(posedge clk) begin
        m_tready <= random_ready ? (rand_below(4) != 0) : 1'b1;
    end

    always @(posedge clk) begin : compare_out
        logic [33:0] exp_beat;
        cycle = cycle + 1;
        if (!rst && m_tvalid && m_tready) begin
            if (exp_q.size() == 0) begin
                $display("ERR %0t: output beat %h with nothing expected", $time, m_tdata);
                err_count++;
            end else begin
                exp_beat = exp_q.pop_front();
                check_value("m_tdata", m_tdata, exp_beat[31:0]);
                check_value("m_tlast", 32'(m_tlast), 32'(exp_beat[32]));
                check_value("m_tuser", 32'(m_tuser), 32'(exp_beat[33]));
            end
            if (gapless) begin
                if (burst_outs > 0) check_value("streaming gap", cycle - prev_cycle, 32'd1);
                prev_cycle = cycle;
                burst_outs++;
            end
        end
    end

    initial begin
        rst      = 1'b1;
        s_tdata  = '0;
        s_tlast  = 1'b0;
        s_tvalid = 1'b0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        // nothing may leave an empty pipeline
        repeat (3) begin
            @(posedge clk);
            check_value("m_tvalid after reset", 32'(m_tvalid), 32'd0);
        end
        // first four packets carry payload under each opcode in turn
        for (int p = 0; p < 40; p++) begin
            send_packet((p < 4) ? 2'(p) : 2'(rand_below(4)), rand_below(5) == 0,
                        (p < 4) ? 1 + rand_below(7) : rand_below(8), 1'b1);
        end
        // header-only packet announcing payload
        send_packet(pkt_fmt_pkg::OP_PASS, 1'b1, 0, 1'b1);
        s_tvalid <= 1'b0;
        wait_drained();
        // back-to-back beats with the sink always ready
        random_ready = 1'b0;
        gapless      = 1'b1;
        send_packet(pkt_fmt_pkg::OP_ADD, 1'b0, 10, 1'b0);
        s_tvalid <= 1'b0;
        wait_drained();
        gapless = 1'b0;
        check_value("streaming beat count", burst_outs, 32'd11);
        $display("errors: %0d mismatches, %0d timeouts", err_count, timeout_count);
        if (err_count == 0 && timeout_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
